// ==== all.f ====
source/video_pkg.sv
source/mem_pkg.sv
source/clock_enables.sv
source/video_timing.sv
source/char_layer.sv
source/rom_loader.sv
source/rom_arbiter.sv
source/game_top.sv
verif/tb_rom_model.sv
verif/game_top_tb.sv

// ==== verif/game_top_tb.sv ====
// ######################################
// Game top testbench
// Downloads a ROM image, draws frames
// and checks pixels, raster counts and
// the memory port
// ######################################

`timescale 1ns/1ps

module game_top_tb;

localparam int h_active      = 48;
localparam int h_total       = 64;
localparam int v_active      = 32;
localparam int v_total       = 40;
localparam int cols          = h_active / 8;
localparam int map_bytes_n   = 2 * cols * (v_active / 8);
// Eight tile codes of eight rows each
localparam int gfx_bytes_n   = 2 * 8 * 8;
localparam int words_n       = (map_bytes_n + gfx_bytes_n) / 2;
localparam int pixels_n      = h_active * v_active;
localparam int gfx_byte_base = 2 * int'(mem_pkg::gfx_base);
localparam int frame_timeout = 4 * h_total * v_total * 4;
localparam int settle_pxl    = 24;
localparam int n_tests       = 5;

typedef enum logic [1:0] {op_download, op_frame, op_frame_off} op_t;

logic               clk, rst_n, downloading, ioctl_wr, char_en;
mem_pkg::dl_addr_t  ioctl_addr;
logic [7:0]         ioctl_data;
logic               pxl2_cen, pxl_cen, hs, vs, lhbl_dly, lvbl_dly;
video_pkg::pxl_t    pxl;
logic               dwnld_busy, mem_rd, mem_wr, mem_ack, mem_dok;
mem_pkg::rom_addr_t mem_addr;
mem_pkg::rom_data_t mem_din, data_read;

// Local copy of the ROM image
logic [7:0] map_img [map_bytes_n];
logic [7:0] gfx_img [gfx_bytes_n];

string      test_name  [n_tests];
op_t        test_op    [n_tests];
int         test_count [n_tests];
int         errors, passed, failed;
int         rd_seen, nz_pix;
int         dl_count;
logic       watch_dl;
logic [31:0] lfsr;

game_top #(
    .h_active   ( h_active ),
    .h_total    ( h_total  ),
    .v_active   ( v_active ),
    .v_total    ( v_total  )
) uut (
    .clk        ( clk         ),
    .rst_n      ( rst_n       ),
    .pxl2_cen   ( pxl2_cen    ),
    .pxl_cen    ( pxl_cen     ),
    .hs         ( hs          ),
    .vs         ( vs          ),
    .lhbl_dly   ( lhbl_dly    ),
    .lvbl_dly   ( lvbl_dly    ),
    .pxl        ( pxl         ),
    .char_en    ( char_en     ),
    .downloading( downloading ),
    .dwnld_busy ( dwnld_busy  ),
    .ioctl_wr   ( ioctl_wr    ),
    .ioctl_addr ( ioctl_addr  ),
    .ioctl_data ( ioctl_data  ),
    .mem_addr   ( mem_addr    ),
    .mem_din    ( mem_din     ),
    .mem_rd     ( mem_rd      ),
    .mem_wr     ( mem_wr      ),
    .mem_ack    ( mem_ack     ),
    .mem_dok    ( mem_dok     ),
    .data_read  ( data_read   )
);

tb_rom_model u_rom (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .mem_addr   ( mem_addr  ),
    .mem_din    ( mem_din   ),
    .mem_rd     ( mem_rd    ),
    .mem_wr     ( mem_wr    ),
    .mem_ack    ( mem_ack   ),
    .mem_dok    ( mem_dok   ),
    .data_read  ( data_read )
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

// Reads and lit pixels seen while a download runs
always @(negedge clk) begin
    if (watch_dl) begin
        if (mem_rd) begin
            rd_seen++;
        end
        if (pxl_cen && lhbl_dly && lvbl_dly && pxl != 2'd0) begin
            nz_pix++;
        end
    end
end

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [7:0] next_random_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
        lfsr = lfsr_next(lfsr);
        b    = {b[6:0], lfsr[0]};
    end
    return b;
endfunction

// Tile code from the map, then the row word, leftmost pixel on top
function automatic video_pkg::pxl_t expected_pixel(input int x, input int y);
    int          code;
    int          word;
    logic [15:0] row;
    code = map_img[2 * ((y / 8) * cols + x / 8)];
    word = code * 8 + y % 8;
    row  = {gfx_img[2 * word + 1], gfx_img[2 * word]};
    return row[15 - 2 * (x % 8) -: 2];
endfunction

task automatic check_value(input string tname, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        errors++;
        $display("FAILED %s expected 0x%0h actual 0x%0h", tname, expected, actual);
    end
endtask

task automatic report_test(input string tname, input int err_before);
    if (errors == err_before) begin
        passed++;
        $display("%s: ok", tname);
    end else begin
        failed++;
        $display("%s: failed with %0d errors", tname, errors - err_before);
    end
endtask

task automatic send_byte(input mem_pkg::dl_addr_t addr, input logic [7:0] data);
    @(posedge clk);
    #2;
    ioctl_wr   = 1'b1;
    ioctl_addr = addr;
    ioctl_data = data;
    @(posedge clk);
    #2;
    ioctl_wr = 1'b0;
    // No back-pressure, strobes stay 12 clk apart
    repeat (10) @(posedge clk);
endtask

task automatic load_rom(input string tname, input int exp_words);
    int cycles;
    int n;
    int words;
    int want;
    // Map codes shift with each download so every map word changes
    for (int w = 0; w < map_bytes_n / 2; w++) begin
        map_img[2 * w]     = 8'((w * 5 + 3 + dl_count) % 8);
        map_img[2 * w + 1] = 8'(w) | 8'h80;
    end
    dl_count++;
    for (int i = 0; i < gfx_bytes_n; i++) begin
        gfx_img[i] = next_random_byte();
    end
    rd_seen = 0;
    nz_pix  = 0;
    @(posedge clk);
    #2;
    char_en     = 1'b1;
    downloading = 1'b1;
    // A read already on the port is allowed to finish
    cycles = 0;
    @(negedge clk);
    while (mem_rd && cycles < 100) begin
        @(negedge clk);
        cycles++;
    end
    if (mem_rd) begin
        errors++;
        $display("Timeout waiting for mem_rd to drop at download start");
    end
    // Last fetched tile shifts out
    n      = 0;
    cycles = 0;
    while (n < settle_pxl && cycles < 1000) begin
        @(negedge clk);
        if (pxl_cen) begin
            n++;
        end
        cycles++;
    end
    if (n < settle_pxl) begin
        errors++;
        $display("Timeout waiting for pxl_cen before download");
    end
    watch_dl = 1'b1;
    for (int i = 0; i < map_bytes_n; i++) begin
        send_byte(mem_pkg::dl_addr_t'(i), map_img[i]);
    end
    for (int i = 0; i < gfx_bytes_n; i++) begin
        send_byte(mem_pkg::dl_addr_t'(gfx_byte_base + i), gfx_img[i]);
    end
    @(posedge clk);
    #2;
    downloading = 1'b0;
    watch_dl    = 1'b0;
    cycles      = 0;
    @(negedge clk);
    while (dwnld_busy && cycles < 100) begin
        @(negedge clk);
        cycles++;
    end
    if (dwnld_busy) begin
        errors++;
        $display("Timeout waiting for dwnld_busy to fall after download");
    end
    check_value({tname, " mem_rd"}, 0, rd_seen);
    check_value({tname, " pixels"}, 0, nz_pix);
    words = 0;
    for (int w = 0; w < map_bytes_n / 2; w++) begin
        want = map_img[2 * w] + 256 * map_img[2 * w + 1];
        check_value(tname, want, u_rom.mem[w]);
        if (u_rom.mem[w] === want[15:0]) begin
            words++;
        end
    end
    for (int w = 0; w < gfx_bytes_n / 2; w++) begin
        want = gfx_img[2 * w] + 256 * gfx_img[2 * w + 1];
        check_value(tname, want, u_rom.mem[int'(mem_pkg::gfx_base) + w]);
        if (u_rom.mem[int'(mem_pkg::gfx_base) + w] === want[15:0]) begin
            words++;
        end
    end
    check_value({tname, " words"}, exp_words, words);
endtask

// Sync on vs, then check one frame from lvbl_dly rise to the next
task automatic draw_frame(input string tname, input logic layer_on, input int exp_pixels);
    int              cycles;
    int              phase;
    int              pix;
    int              vs_n;
    int              hs_n;
    int              line_len;
    int              half_len;
    logic            vs_q, hs_q, lv_q, hs_seen;
    video_pkg::pxl_t want;
    @(posedge clk);
    #2;
    char_en  = layer_on;
    phase    = 0;
    pix      = 0;
    vs_n     = 0;
    hs_n     = 0;
    line_len = 0;
    half_len = 0;
    hs_seen  = 1'b0;
    // Start high so a level already up is not taken as an edge
    vs_q     = 1'b1;
    hs_q     = 1'b1;
    lv_q     = 1'b1;
    cycles   = 0;
    while (phase < 3 && cycles < frame_timeout) begin
        @(negedge clk);
        cycles++;
        if (phase == 2 && lvbl_dly && !lv_q) begin
            phase = 3;
        end
        if (phase == 1 && lvbl_dly && !lv_q) begin
            phase = 2;
        end
        if (phase == 0 && vs && !vs_q) begin
            phase = 1;
        end
        if (phase == 2) begin
            if (pxl_cen) begin
                line_len++;
                // pxl_cen lands on every other pxl2_cen
                check_value({tname, " pxl2_cen"}, 1, pxl2_cen);
            end
            if (pxl2_cen) begin
                half_len++;
            end
            if (vs && !vs_q) begin
                vs_n++;
            end
            if (hs && !hs_q) begin
                hs_n++;
                if (hs_seen) begin
                    check_value({tname, " line"}, h_total, line_len);
                    check_value({tname, " half dots"}, 2 * h_total, half_len);
                end
                hs_seen  = 1'b1;
                line_len = 0;
                half_len = 0;
            end
            if (pxl_cen && lhbl_dly && lvbl_dly) begin
                want = layer_on ? expected_pixel(pix % h_active, pix / h_active) : 2'd0;
                if (pix < pixels_n) begin
                    check_value(tname, want, pxl);
                end
                pix++;
            end
        end
        vs_q = vs;
        hs_q = hs;
        lv_q = lvbl_dly;
    end
    if (phase < 3) begin
        errors++;
        $display("Timeout waiting for a full frame between lvbl_dly rising edges");
    end else begin
        check_value({tname, " vs"}, 1, vs_n);
        check_value({tname, " hs"}, v_total, hs_n);
        check_value({tname, " pixels"}, exp_pixels, pix);
    end
endtask

initial begin : main
    int err0;
    rst_n       = 1'b0;
    downloading = 1'b0;
    ioctl_wr    = 1'b0;
    ioctl_addr  = '0;
    ioctl_data  = '0;
    char_en     = 1'b1;
    watch_dl    = 1'b0;
    rd_seen     = 0;
    nz_pix      = 0;
    dl_count    = 0;
    errors      = 0;
    passed      = 0;
    failed      = 0;
    lfsr        = 32'hf855_e4e3;

    test_name[0]  = "download_rom";
    test_op[0]    = op_download;
    test_count[0] = words_n;
    test_name[1]  = "frame_chars";
    test_op[1]    = op_frame;
    test_count[1] = pixels_n;
    test_name[2]  = "frame_layer_off";
    test_op[2]    = op_frame_off;
    test_count[2] = pixels_n;
    test_name[3]  = "second_download";
    test_op[3]    = op_download;
    test_count[3] = words_n;
    test_name[4]  = "frame_after_reload";
    test_op[4]    = op_frame;
    test_count[4] = pixels_n;

    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    err0 = errors;
    @(negedge clk);
    check_value("reset_state mem_rd", 0, mem_rd);
    check_value("reset_state mem_wr", 0, mem_wr);
    check_value("reset_state dwnld_busy", 0, dwnld_busy);
    check_value("reset_state hs", 0, hs);
    check_value("reset_state vs", 0, vs);
    check_value("reset_state lhbl_dly", 0, lhbl_dly);
    check_value("reset_state lvbl_dly", 0, lvbl_dly);
    check_value("reset_state pxl", 0, pxl);
    report_test("reset_state", err0);

    for (int t = 0; t < n_tests; t++) begin
        err0 = errors;
        case (test_op[t])
            op_download:  load_rom(test_name[t], test_count[t]);
            op_frame:     draw_frame(test_name[t], 1'b1, test_count[t]);
            op_frame_off: draw_frame(test_name[t], 1'b0, test_count[t]);
            default: begin
                errors++;
                $display("Unknown operation in test %0d", t);
            end
        endcase
        report_test(test_name[t], err0);
    end

    $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
    if (failed == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

// ==== verif/tb_rom_model.sv ====
// ######################################
// ROM model for the testbench
// 64k words, stores writes and answers
// each request after 1 to 4 cycles
// ######################################

`timescale 1ns/1ps

module tb_rom_model (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_pkg::rom_addr_t mem_addr,
    input  mem_pkg::rom_data_t mem_din,
    input  logic               mem_rd,
    input  logic               mem_wr,
    output logic               mem_ack,
    output logic               mem_dok,
    output mem_pkg::rom_data_t data_read
);

mem_pkg::rom_data_t mem [0:65535];
mem_pkg::rom_data_t rdata_q;
logic [31:0]        lfsr;
logic [1:0]         delay;
logic [1:0]         wait_cnt;
logic               busy;
logic               ack_q;
logic               dok_q;

// Outputs settle a little after the clock edge
assign #2 mem_ack   = ack_q;
assign #2 mem_dok   = dok_q;
assign #2 data_read = rdata_q;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

initial begin
    lfsr     = 32'hf855_e4e3;
    busy     = 1'b0;
    wait_cnt = 2'd0;
    ack_q    = 1'b0;
    dok_q    = 1'b0;
    rdata_q  = '0;
    // Fill depends on every address bit
    for (int i = 0; i < 65536; i++) begin
        mem[i] = ~16'(i);
    end
end

always @(posedge clk) begin
    ack_q <= 1'b0;
    dok_q <= 1'b0;
    if (!rst_n) begin
        busy <= 1'b0;
    end else if (ack_q) begin
        // Request drops on this edge
        busy <= 1'b0;
    end else if (!busy && (mem_rd || mem_wr)) begin
        lfsr     = lfsr_next(lfsr);
        delay[0] = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        delay[1] = lfsr[0];
        wait_cnt <= delay;
        busy     <= 1'b1;
    end else if (busy) begin
        if (wait_cnt == 2'd0) begin
            busy  <= 1'b0;
            ack_q <= 1'b1;
            if (mem_wr) begin
                mem[mem_addr] <= mem_din;
            end else begin
                dok_q   <= 1'b1;
                rdata_q <= mem[mem_addr];
            end
        end else begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end
end

endmodule

// ==== source/game_top.sv ====
// ######################################
// Game top level
// Clock enables, raster timing, one
// character layer and the ROM download
// on a shared memory port
// ######################################

`timescale 1ns/1ps

module game_top #(
    parameter int h_active = 48,
    parameter int h_total  = 64,
    parameter int v_active = 32,
    parameter int v_total  = 40
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic               pxl2_cen,
    output logic               pxl_cen,
    output logic               hs,
    output logic               vs,
    output logic               lhbl_dly,
    output logic               lvbl_dly,
    output video_pkg::pxl_t    pxl,
    input  logic               char_en,
    // ROM download
    input  logic               downloading,
    output logic               dwnld_busy,
    input  logic               ioctl_wr,
    input  mem_pkg::dl_addr_t  ioctl_addr,
    input  logic [7:0]         ioctl_data,
    // External memory
    output mem_pkg::rom_addr_t mem_addr,
    output mem_pkg::rom_data_t mem_din,
    output logic               mem_rd,
    output logic               mem_wr,
    input  logic               mem_ack,
    input  logic               mem_dok,
    input  mem_pkg::rom_data_t data_read
);

// Video signals
video_pkg::hcnt_t   hdump;
video_pkg::vcnt_t   vdump;
logic               lhbl, lvbl, tile_strobe;

// Character fetch
logic               chr_rd, chr_ok;
mem_pkg::rom_addr_t chr_addr;
mem_pkg::rom_data_t chr_data;

// Loader writes
logic               ld_wr, ld_ack;
mem_pkg::rom_addr_t ld_addr;
mem_pkg::rom_data_t ld_din;

clock_enables u_cen (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .pxl2_cen   ( pxl2_cen  ),
    .pxl_cen    ( pxl_cen   )
);

video_timing #(
    .h_active   ( h_active  ),
    .h_total    ( h_total   ),
    .v_active   ( v_active  ),
    .v_total    ( v_total   )
) u_timing (
    .clk        ( clk         ),
    .rst_n      ( rst_n       ),
    .pxl_cen    ( pxl_cen     ),
    .hdump      ( hdump       ),
    .vdump      ( vdump       ),
    .lhbl       ( lhbl        ),
    .lvbl       ( lvbl        ),
    .hs         ( hs          ),
    .vs         ( vs          ),
    .tile_strobe( tile_strobe )
);

char_layer #(
    .h_active   ( h_active  )
) u_char (
    .clk        ( clk         ),
    .rst_n      ( rst_n       ),
    .pxl_cen    ( pxl_cen     ),
    .tile_strobe( tile_strobe ),
    .lhbl       ( lhbl        ),
    .lvbl       ( lvbl        ),
    .hdump      ( hdump       ),
    .vdump      ( vdump       ),
    .char_en    ( char_en     ),
    .chr_rd     ( chr_rd      ),
    .chr_addr   ( chr_addr    ),
    .chr_data   ( chr_data    ),
    .chr_ok     ( chr_ok      ),
    .pxl        ( pxl         ),
    .lhbl_dly   ( lhbl_dly    ),
    .lvbl_dly   ( lvbl_dly    )
);

rom_loader u_loader (
    .clk        ( clk         ),
    .rst_n      ( rst_n       ),
    .downloading( downloading ),
    .ioctl_wr   ( ioctl_wr    ),
    .ioctl_addr ( ioctl_addr  ),
    .ioctl_data ( ioctl_data  ),
    .ld_wr      ( ld_wr       ),
    .ld_addr    ( ld_addr     ),
    .ld_din     ( ld_din      ),
    .ld_ack     ( ld_ack      ),
    .dwnld_busy ( dwnld_busy  )
);

rom_arbiter u_arbiter (
    .clk        ( clk         ),
    .rst_n      ( rst_n       ),
    .dwnld_busy ( dwnld_busy  ),
    .ld_wr      ( ld_wr       ),
    .ld_addr    ( ld_addr     ),
    .ld_din     ( ld_din      ),
    .ld_ack     ( ld_ack      ),
    .chr_rd     ( chr_rd      ),
    .chr_addr   ( chr_addr    ),
    .chr_data   ( chr_data    ),
    .chr_ok     ( chr_ok      ),
    .mem_addr   ( mem_addr    ),
    .mem_din    ( mem_din     ),
    .mem_rd     ( mem_rd      ),
    .mem_wr     ( mem_wr      ),
    .mem_ack    ( mem_ack     ),
    .mem_dok    ( mem_dok     ),
    .data_read  ( data_read   )
);

endmodule

// ==== source/rom_arbiter.sv ====
// ######################################
// ROM port arbiter
// Shares the external memory port
// between the loader and the character
// layer
// ######################################

`timescale 1ns/1ps

module rom_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dwnld_busy,
    input  logic               ld_wr,
    input  mem_pkg::rom_addr_t ld_addr,
    input  mem_pkg::rom_data_t ld_din,
    output logic               ld_ack,
    input  logic               chr_rd,
    input  mem_pkg::rom_addr_t chr_addr,
    output mem_pkg::rom_data_t chr_data,
    output logic               chr_ok,
    output mem_pkg::rom_addr_t mem_addr,
    output mem_pkg::rom_data_t mem_din,
    output logic               mem_rd,
    output logic               mem_wr,
    input  logic               mem_ack,
    input  logic               mem_dok,
    input  mem_pkg::rom_data_t data_read
);

typedef enum logic [1:0] {idle, wr_busy, rd_busy} arb_state_t;

arb_state_t state;
logic       grant_wr;
logic       grant_rd;

// Requests still high during their own ack are not granted again
assign grant_wr = state == idle && ld_wr && !ld_ack;
assign grant_rd = state == idle && !grant_wr && !dwnld_busy && chr_rd && !chr_ok;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state  <= idle;
        mem_rd <= 1'b0;
        mem_wr <= 1'b0;
        ld_ack <= 1'b0;
        chr_ok <= 1'b0;
    end else begin
        ld_ack <= 1'b0;
        chr_ok <= 1'b0;
        case (state)
            idle: begin
                if (grant_wr) begin
                    mem_wr <= 1'b1;
                    state  <= wr_busy;
                end else if (grant_rd) begin
                    mem_rd <= 1'b1;
                    state  <= rd_busy;
                end
            end
            wr_busy: begin
                if (mem_ack) begin
                    mem_wr <= 1'b0;
                    ld_ack <= 1'b1;
                    state  <= idle;
                end
            end
            rd_busy: begin
                // Data may trail the ack
                if (mem_ack || mem_dok) begin
                    mem_rd <= 1'b0;
                end
                if (mem_dok) begin
                    chr_ok <= 1'b1;
                    state  <= idle;
                end
            end
            default: state <= idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (grant_wr) begin
        mem_addr <= ld_addr;
        mem_din  <= ld_din;
    end else if (grant_rd) begin
        mem_addr <= chr_addr;
    end
    if (state == rd_busy && mem_dok) begin
        chr_data <= data_read;
    end
end

endmodule

// ==== source/rom_loader.sv ====
// ######################################
// ROM download
// Packs loader bytes into 16-bit words
// and writes them to the ROM port
// ######################################

`timescale 1ns/1ps

module rom_loader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    input  logic               ioctl_wr,
    input  mem_pkg::dl_addr_t  ioctl_addr,
    input  logic [7:0]         ioctl_data,
    output logic               ld_wr,
    output mem_pkg::rom_addr_t ld_addr,
    output mem_pkg::rom_data_t ld_din,
    input  logic               ld_ack,
    output logic               dwnld_busy
);

logic [7:0] low_byte;
logic       byte_in;

assign byte_in = downloading && ioctl_wr;

// Write request stays up until the arbiter takes it
always_ff @(posedge clk) begin
    if (!rst_n) begin
        ld_wr <= 1'b0;
    end else if (byte_in && ioctl_addr[0]) begin
        ld_wr <= 1'b1;
    end else if (ld_ack) begin
        ld_wr <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (byte_in) begin
        if (!ioctl_addr[0]) begin
            low_byte <= ioctl_data;
        end else begin
            // Odd byte goes on top
            ld_din  <= {ioctl_data, low_byte};
            ld_addr <= ioctl_addr[16:1];
        end
    end
end

assign dwnld_busy = downloading | ld_wr;

endmodule

// ==== source/char_layer.sv ====
// ######################################
// Character layer
// Fetches map and graphics of each 8x8
// tile and shifts out its pixels one
// tile later
// ######################################

`timescale 1ns/1ps

module char_layer #(
    parameter int h_active = 48
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  logic               tile_strobe,
    input  logic               lhbl,
    input  logic               lvbl,
    input  video_pkg::hcnt_t   hdump,
    input  video_pkg::vcnt_t   vdump,
    input  logic               char_en,
    output logic               chr_rd,
    output mem_pkg::rom_addr_t chr_addr,
    input  mem_pkg::rom_data_t chr_data,
    input  logic               chr_ok,
    output video_pkg::pxl_t    pxl,
    output logic               lhbl_dly,
    output logic               lvbl_dly
);

// Map width in tiles
localparam int cols = h_active / 8;

typedef enum logic [1:0] {idle, map_rd, gfx_rd} fetch_state_t;

fetch_state_t          state;
logic                  stale;
logic                  drop;
logic                  row_ok;
logic [2:0]            vrow_l;
logic [5:0]            fetch_col;
logic [7:0]            hb_dly;
logic [7:0]            vb_dly;
video_pkg::tile_code_t tile_code;
video_pkg::gfx_row_t   row_buf;
video_pkg::gfx_row_t   shift;
mem_pkg::rom_addr_t    map_addr;
mem_pkg::rom_addr_t    gfx_addr;

assign fetch_col = hdump[8:3];
assign tile_code = chr_data[7:0];

assign map_addr = mem_pkg::rom_addr_t'(vdump[8:3]) * mem_pkg::rom_addr_t'(cols)
                + mem_pkg::rom_addr_t'(fetch_col);
assign gfx_addr = mem_pkg::gfx_base + {5'd0, tile_code, 3'd0} + {13'd0, vrow_l};

// A strobe during a fetch spoils its result
assign drop = stale | tile_strobe;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state  <= idle;
        chr_rd <= 1'b0;
        stale  <= 1'b0;
        row_ok <= 1'b0;
    end else begin
        if (tile_strobe && state != idle) begin
            stale <= 1'b1;
        end else if (state == idle) begin
            stale <= 1'b0;
        end
        // Row is consumed by the shifter
        if (tile_strobe) begin
            row_ok <= 1'b0;
        end
        case (state)
            idle: begin
                if (tile_strobe && fetch_col < 6'(cols)) begin
                    chr_rd <= 1'b1;
                    state  <= map_rd;
                end
            end
            map_rd: begin
                if (chr_ok) begin
                    if (drop) begin
                        chr_rd <= 1'b0;
                        state  <= idle;
                    end else begin
                        state <= gfx_rd;
                    end
                end
            end
            gfx_rd: begin
                if (chr_ok) begin
                    chr_rd <= 1'b0;
                    state  <= idle;
                    if (!drop) begin
                        row_ok <= 1'b1;
                    end
                end
            end
            default: state <= idle;
        endcase
    end
end

// Request address and fetched row
always_ff @(posedge clk) begin
    if (state == idle && tile_strobe) begin
        chr_addr <= map_addr;
        vrow_l   <= vdump[2:0];
    end
    if (state == map_rd && chr_ok) begin
        chr_addr <= gfx_addr;
    end
    if (state == gfx_rd && chr_ok) begin
        row_buf <= chr_data;
    end
end

// Pixel shifter and blanking delay
always_ff @(posedge clk) begin
    if (!rst_n) begin
        shift  <= '0;
        hb_dly <= '0;
        vb_dly <= '0;
    end else if (pxl_cen) begin
        hb_dly <= {hb_dly[6:0], lhbl};
        vb_dly <= {vb_dly[6:0], lvbl};
        if (tile_strobe) begin
            // Late or missing fetch draws a blank tile
            shift <= row_ok ? row_buf : '0;
        end else begin
            shift <= {shift[13:0], 2'b00};
        end
    end
end

assign lhbl_dly = hb_dly[7];
assign lvbl_dly = vb_dly[7];
assign pxl      = (lhbl_dly && lvbl_dly && char_en) ? shift[15:14] : 2'd0;

endmodule

// ==== source/video_timing.sv ====
// ######################################
// Raster timing
// Dot and line counters, sync, blanking
// and the per-tile fetch strobe
// ######################################

`timescale 1ns/1ps

module video_timing #(
    parameter int h_active = 48,
    parameter int h_total  = 64,
    parameter int v_active = 32,
    parameter int v_total  = 40
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    output video_pkg::hcnt_t  hdump,
    output video_pkg::vcnt_t  vdump,
    output logic              lhbl,
    output logic              lvbl,
    output logic              hs,
    output logic              vs,
    output logic              tile_strobe
);

localparam video_pkg::hcnt_t h_last   = video_pkg::hcnt_t'(h_total - 1);
localparam video_pkg::vcnt_t v_last   = video_pkg::vcnt_t'(v_total - 1);
localparam video_pkg::hcnt_t hs_start = video_pkg::hcnt_t'(h_active);
localparam video_pkg::hcnt_t hs_end   = video_pkg::hcnt_t'(h_active + 8);
localparam video_pkg::vcnt_t vs_start = video_pkg::vcnt_t'(v_active);
localparam video_pkg::vcnt_t vs_end   = video_pkg::vcnt_t'(v_active + 2);

// Counters
always_ff @(posedge clk) begin
    if (!rst_n) begin
        hdump <= '0;
        vdump <= '0;
    end else if (pxl_cen) begin
        if (hdump == h_last) begin
            hdump <= '0;
            if (vdump == v_last) begin
                vdump <= '0;
            end else begin
                vdump <= vdump + 1'b1;
            end
        end else begin
            hdump <= hdump + 1'b1;
        end
    end
end

// Sync and blanking, one dot behind the counters
always_ff @(posedge clk) begin
    if (!rst_n) begin
        lhbl <= 1'b0;
        lvbl <= 1'b0;
        hs   <= 1'b0;
        vs   <= 1'b0;
    end else if (pxl_cen) begin
        lhbl <= hdump < hs_start;
        lvbl <= vdump < vs_start;
        // 8 dots right after the active area
        hs   <= hdump >= hs_start && hdump < hs_end;
        // 2 lines right after the active area
        vs   <= vdump >= vs_start && vdump < vs_end;
    end
end

// Tile boundary, the last tile of the line included
assign tile_strobe = pxl_cen && hdump[2:0] == 3'd0;

endmodule

// ==== source/clock_enables.sv ====
// ######################################
// Pixel clock enables
// Divides clk into a half rate and a
// quarter rate strobe
// ######################################

`timescale 1ns/1ps

module clock_enables (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

logic [1:0] phase;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        phase    <= 2'd0;
        pxl2_cen <= 1'b0;
        pxl_cen  <= 1'b0;
    end else begin
        phase    <= phase + 2'd1;
        // Every odd phase gives the 2x strobe
        pxl2_cen <= phase[0];
        // Last phase only, so it lands on every other pxl2_cen
        pxl_cen  <= phase == 2'd3;
    end
end

endmodule

// ==== source/mem_pkg.sv ====
// ######################################
// Memory types
// ROM port addresses and data, download
// byte addresses and the ROM layout
// ######################################

package mem_pkg;

    // Word address on the ROM port
    typedef logic [15:0] rom_addr_t;

    // ROM data word
    typedef logic [15:0] rom_data_t;

    // Byte address from the loader
    typedef logic [16:0] dl_addr_t;

    // Graphics area start, tile map sits at word 0
    localparam rom_addr_t gfx_base = 16'h0100;

endpackage

// ==== source/video_pkg.sv ====
// ######################################
// Video types
// Raster counters, tile codes and pixel
// values shared by the timing generator
// and the character layer
// ######################################

package video_pkg;

    // Horizontal dot counter
    typedef logic [8:0] hcnt_t;

    // Line counter
    typedef logic [8:0] vcnt_t;

    // Tile number read from the map
    typedef logic [7:0] tile_code_t;

    // Colour index of one pixel
    typedef logic [1:0] pxl_t;

    // One tile line of eight 2-bit pixels
    // Leftmost pixel sits in bits 15:14
    typedef logic [15:0] gfx_row_t;

endpackage
